// ==== Makefile ====
VERILATOR ?= verilator
FLAGS := --binary --timing --assert
LINT_FLAGS := --lint-only --timing --assert -Wall
TOP := invaders_tb
FILELIST := compile.f
OBJ_DIR := obj_dir
BIN := $(OBJ_DIR)/V$(TOP)
LOG := sim.log

.PHONY: all run lint clean

all: run

$(BIN): $(FILELIST) $(wildcard logic/*.sv tests/*.sv)
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== compile.f ====
logic/invaders_pkg.sv
logic/player_control.sv
logic/shot_slot.sv
logic/invader_formation.sv
logic/pixel_render.sv
logic/invaders_top.sv
tests/invaders_tb.sv

// ==== logic/invader_formation.sv ====
`default_nettype none

module invader_formation
	import invaders_pkg::*;
#(
	parameter int NUM_SHOTS = 3
)
(
	input wire logic clk,
	input wire logic rst_n,
	input wire logic frame_tick,
	input alive_t [NUM_SHOTS-1:0] kill,
	output coord_t formation_x,
	output coord_t formation_y,
	output alive_t alive
);

	// rightmost origin that keeps the formation on screen
	localparam coord_t RIGHT_LIMIT = SCREEN_W - FORM_W;

	alive_t kill_any;
	coord_t drop_y;
	logic move_right;

	// merge the per-shot kill masks
	always_comb
	begin
		kill_any = '0;
		for (int i = 0; i < NUM_SHOTS; i++)
			kill_any = kill_any | kill[i];
	end

	// drop, clamped so the bottom row rests on the floor
	assign drop_y = (formation_y + FORM_H + DROP_STEP > FLOOR_Y) ?
		FLOOR_Y - FORM_H : formation_y + DROP_STEP;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			alive <= '1;
			formation_x <= FORM_X0;
			formation_y <= FORM_Y0;
			move_right <= 1'b0;
		end
		else if (frame_tick)
		begin
			alive <= alive & ~kill_any;
			if (!move_right)
			begin
				// left edge reached
				if (formation_x == '0)
				begin
					move_right <= 1'b1;
					formation_y <= drop_y;
				end
				else if (formation_x < MARCH_STEP)
					formation_x <= '0;
				else
					formation_x <= formation_x - MARCH_STEP;
			end
			else
			begin
				// right edge reached
				if (formation_x == RIGHT_LIMIT)
				begin
					move_right <= 1'b0;
					formation_y <= drop_y;
				end
				else if (RIGHT_LIMIT - formation_x < MARCH_STEP)
					formation_x <= RIGHT_LIMIT;
				else
					formation_x <= formation_x + MARCH_STEP;
			end
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) formation_y + FORM_H <= FLOOR_Y);

endmodule

`default_nettype wire

// ==== logic/invaders_pkg.sv ====
`default_nettype none

package invaders_pkg;

	typedef logic [10:0] coord_t;
	typedef logic [7:0] rgb_t;
	// bit index is row * COLS + col, row 0 on top
	typedef logic [32:0] alive_t;

	// visible area
	localparam coord_t SCREEN_W = 11'd640;
	localparam coord_t SCREEN_H = 11'd480;

	// formation geometry
	localparam int ROWS = 3;
	localparam int COLS = 11;
	localparam int ENEMY_COUNT = ROWS * COLS;
	localparam coord_t CELL = 11'd32;
	// last two columns and rows of each cell stay empty
	localparam coord_t SPRITE = 11'd30;
	localparam coord_t FORM_W = 11'd352;
	localparam coord_t FORM_H = coord_t'(ROWS * 32);
	localparam coord_t FORM_X0 = 11'd128;
	localparam coord_t FORM_Y0 = 11'd64;
	localparam coord_t MARCH_STEP = 11'd1;
	localparam coord_t DROP_STEP = 11'd8;
	localparam coord_t FLOOR_Y = 11'd320;

	// cannon
	localparam coord_t PLAYER_Y = 11'd416;
	localparam coord_t PLAYER_SIZE = 11'd32;
	localparam coord_t PLAYER_X0 = 11'd320;
	localparam coord_t PLAYER_STEP = 11'd1;
	localparam coord_t PLAYER_X_MAX = 11'd608;

	// shots
	localparam coord_t SHOT_SIZE = 11'd4;
	localparam coord_t SHOT_STEP = 11'd4;
	localparam coord_t SHOT_DX = 11'd14;
	localparam coord_t SHOT_DY = 11'd8;

	localparam rgb_t COLOR_BG = 8'b01001000;
	localparam rgb_t COLOR_ENEMY = 8'b11011101;
	localparam rgb_t COLOR_PLAYER = 8'b10010111;
	localparam rgb_t COLOR_SHOT = 8'b11100001;
	localparam rgb_t COLOR_BLANK = 8'b00000000;

	// point (px,py) inside the formation bounding box
	function automatic logic in_formation(coord_t px, coord_t py, coord_t fx, coord_t fy);
		return px >= fx && px < fx + FORM_W && py >= fy && py < fy + FORM_H;
	endfunction

	// alive bit index from the offset to the formation origin
	function automatic logic [5:0] cell_index(coord_t dx, coord_t dy);
		coord_t col;
		coord_t row;
		col = dx / CELL;
		row = dy / CELL;
		return 6'(row * coord_t'(COLS) + col);
	endfunction

endpackage

`default_nettype wire

// ==== logic/invaders_top.sv ====
`default_nettype none

module invaders_top
	import invaders_pkg::*;
#(
	parameter int NUM_SHOTS = 3
)
(
	input wire logic clk,
	input wire logic rst_n,
	input coord_t x,
	input coord_t y,
	input wire logic btn_left,
	input wire logic btn_right,
	input wire logic btn_fire,
	output rgb_t rgb
);

	coord_t player_x;
	logic frame_tick;
	logic [NUM_SHOTS-1:0] fire;
	logic [NUM_SHOTS-1:0] shot_active;
	coord_t [NUM_SHOTS-1:0] shot_x;
	coord_t [NUM_SHOTS-1:0] shot_y;
	alive_t [NUM_SHOTS-1:0] kill;
	coord_t formation_x;
	coord_t formation_y;
	alive_t alive;

	// frame strobe, cannon and launcher
	player_control #(
		.NUM_SHOTS(NUM_SHOTS)
	) i_player (
		.clk(clk),
		.rst_n(rst_n),
		.x(x),
		.y(y),
		.btn_left(btn_left),
		.btn_right(btn_right),
		.btn_fire(btn_fire),
		.shot_active(shot_active),
		.player_x(player_x),
		.frame_tick(frame_tick),
		.fire(fire)
	);

	// one slot per shot
	for (genvar i = 0; i < NUM_SHOTS; i++)
	begin : g_shot
		shot_slot i_shot (
			.clk(clk),
			.rst_n(rst_n),
			.frame_tick(frame_tick),
			.fire(fire[i]),
			.player_x(player_x),
			.formation_x(formation_x),
			.formation_y(formation_y),
			.alive(alive),
			.active(shot_active[i]),
			.shot_x(shot_x[i]),
			.shot_y(shot_y[i]),
			.kill(kill[i])
		);
	end

	invader_formation #(
		.NUM_SHOTS(NUM_SHOTS)
	) i_formation (
		.clk(clk),
		.rst_n(rst_n),
		.frame_tick(frame_tick),
		.kill(kill),
		.formation_x(formation_x),
		.formation_y(formation_y),
		.alive(alive)
	);

	pixel_render #(
		.NUM_SHOTS(NUM_SHOTS)
	) i_render (
		.clk(clk),
		.rst_n(rst_n),
		.x(x),
		.y(y),
		.player_x(player_x),
		.shot_active(shot_active),
		.shot_x(shot_x),
		.shot_y(shot_y),
		.formation_x(formation_x),
		.formation_y(formation_y),
		.alive(alive),
		.rgb(rgb)
	);

endmodule

`default_nettype wire

// ==== logic/pixel_render.sv ====
`default_nettype none

module pixel_render
	import invaders_pkg::*;
#(
	parameter int NUM_SHOTS = 3
)
(
	input wire logic clk,
	input wire logic rst_n,
	input coord_t x,
	input coord_t y,
	input coord_t player_x,
	input wire logic [NUM_SHOTS-1:0] shot_active,
	input coord_t [NUM_SHOTS-1:0] shot_x,
	input coord_t [NUM_SHOTS-1:0] shot_y,
	input coord_t formation_x,
	input coord_t formation_y,
	input alive_t alive,
	output rgb_t rgb
);

	logic visible;
	logic shot_px;
	logic player_px;
	logic enemy_px;
	coord_t dx;
	coord_t dy;

	assign visible = x < SCREEN_W && y < SCREEN_H;

	// any live shot square covers the pixel
	always_comb
	begin
		shot_px = 1'b0;
		for (int i = 0; i < NUM_SHOTS; i++)
		begin
			if (shot_active[i] && x >= shot_x[i] && x < shot_x[i] + SHOT_SIZE
				&& y >= shot_y[i] && y < shot_y[i] + SHOT_SIZE)
				shot_px = 1'b1;
		end
	end

	assign player_px = x >= player_x && x < player_x + PLAYER_SIZE
		&& y >= PLAYER_Y && y < PLAYER_Y + PLAYER_SIZE;

	// solid square per live cell, gap at the cell's right and bottom
	assign dx = x - formation_x;
	assign dy = y - formation_y;
	assign enemy_px = in_formation(x, y, formation_x, formation_y)
		&& (dx % CELL) < SPRITE && (dy % CELL) < SPRITE && alive[cell_index(dx, dy)];

	// one cycle from x,y to colour
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			rgb <= COLOR_BLANK;
		else if (!visible)
			rgb <= COLOR_BLANK;
		else if (shot_px)
			rgb <= COLOR_SHOT;
		else if (player_px)
			rgb <= COLOR_PLAYER;
		else if (enemy_px)
			rgb <= COLOR_ENEMY;
		else
			rgb <= COLOR_BG;
	end

endmodule

`default_nettype wire

// ==== logic/player_control.sv ====
`default_nettype none

module player_control
	import invaders_pkg::*;
#(
	parameter int NUM_SHOTS = 3
)
(
	input wire logic clk,
	input wire logic rst_n,
	input coord_t x,
	input coord_t y,
	input wire logic btn_left,
	input wire logic btn_right,
	input wire logic btn_fire,
	input wire logic [NUM_SHOTS-1:0] shot_active,
	output coord_t player_x,
	output logic frame_tick,
	output logic [NUM_SHOTS-1:0] fire
);

	logic frame_start;
	logic [NUM_SHOTS-1:0] free_slot;

	// first pixel of the frame
	assign frame_start = (x == '0) && (y == '0);

	// lowest clear bit of shot_active, zero when all slots are busy
	assign free_slot = ~shot_active & (shot_active + NUM_SHOTS'(1));

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			player_x <= PLAYER_X0;
			frame_tick <= 1'b0;
			fire <= '0;
		end
		else
		begin
			// strobes last one cycle
			frame_tick <= frame_start;
			fire <= '0;
			if (frame_start)
			begin
				// left wins when both buttons are held
				if (btn_left && player_x > PLAYER_STEP)
					player_x <= player_x - PLAYER_STEP;
				else if (btn_right && player_x < PLAYER_X_MAX)
					player_x <= player_x + PLAYER_STEP;
				if (btn_fire)
					fire <= free_slot;
			end
		end
	end

	// one slot at a time
	assert property (@(posedge clk) disable iff (!rst_n) $onehot0(fire));

endmodule

`default_nettype wire

// ==== logic/shot_slot.sv ====
`default_nettype none

module shot_slot
	import invaders_pkg::*;
(
	input wire logic clk,
	input wire logic rst_n,
	input wire logic frame_tick,
	input wire logic fire,
	input coord_t player_x,
	input coord_t formation_x,
	input coord_t formation_y,
	input alive_t alive,
	output logic active,
	output coord_t shot_x,
	output coord_t shot_y,
	output alive_t kill
);

	coord_t dx;
	coord_t dy;
	logic [5:0] idx;
	logic hit;

	// offset from the formation origin, meaningful only inside the box
	assign dx = shot_x - formation_x;
	assign dy = shot_y - formation_y;
	assign idx = cell_index(dx, dy);

	// top-left corner of the shot over a live cell
	assign hit = active && !fire && frame_tick
		&& in_formation(shot_x, shot_y, formation_x, formation_y) && alive[idx];

	// combinational so the formation clears the invader on this same edge
	assign kill = hit ? (alive_t'(1'b1) << idx) : '0;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			active <= 1'b0;
		else if (fire)
			active <= 1'b1;
		else if (frame_tick && active && (hit || shot_y < SHOT_STEP))
			active <= 1'b0;
	end

	// launch point, then upward travel once per frame
	always_ff @(posedge clk)
	begin
		if (fire)
		begin
			shot_x <= player_x + SHOT_DX;
			shot_y <= PLAYER_Y - SHOT_DY;
		end
		else if (frame_tick && active && !hit && shot_y >= SHOT_STEP)
			shot_y <= shot_y - SHOT_STEP;
	end

	// launcher only picks free slots
	assert property (@(posedge clk) disable iff (!rst_n) fire |-> !active);

endmodule

`default_nettype wire

// ==== tests/invaders_input.txt ====
# F left right fire count : frames, each pixel (0,0) then two off-screen cycles
# P x y rgb : drive pixel x,y (decimal) and expect rgb (hex) one cycle later; E ends
# after reset
P 128 64 dd
P 158 64 48
P 330 420 97
P 10 10 48
P 700 10 00
# cannon right to 340
F 0 1 0 20
P 339 420 48
P 340 420 97
P 372 420 48
# one shot, then five frames of travel
F 0 0 1 1
P 354 408 e1
P 354 407 48
F 0 0 0 5
P 354 388 e1
P 354 392 48
# shot kills row 2 col 9, origin now x 43
F 0 0 0 59
P 331 128 48
P 299 128 dd
P 43 64 dd
P 42 64 48
# second shot, formation drops to y 72 at the left edge
F 1 0 0 12
F 0 0 1 1
F 0 0 0 31
P 0 72 dd
P 0 71 48
P 342 284 e1
# shot passes the empty cell and kills row 1 col 9
F 0 0 0 39
P 327 104 48
P 327 72 dd
P 295 104 dd
P 39 72 dd
# four fire frames give three shots
F 1 0 0 125
F 1 0 1 4
P 219 396 e1
P 215 400 e1
P 214 404 e1
P 213 408 48
F 0 0 0 99
P 216 0 e1
P 214 8 e1
F 0 0 1 1
P 219 0 48
P 215 0 e1
P 213 408 48
F 0 0 1 1
P 213 408 e1
P 218 0 48
# left limit, formation back from the right edge
F 1 0 0 210
P 0 420 48
P 1 420 97
P 33 420 48
P 98 80 dd
P 97 80 48
E

// ==== tests/invaders_tb.sv ====
`default_nettype none

module invaders_tb;

	localparam string INPUT_FILE = "tests/invaders_input.txt";
	localparam int RESET_CYCLES = 10;
	// off-screen pixel between frame starts and probes
	localparam int IDLE_X = 700;
	localparam int FRAME_CYCLES = 3;
	localparam int PROBE_CYCLES = 2;

	logic clk;
	logic rst_n;
	logic [10:0] x;
	logic [10:0] y;
	logic btn_left;
	logic btn_right;
	logic btn_fire;
	logic [7:0] rgb;

	int checks = 0;
	int errors = 0;
	int cycles = 0;
	int cycle_limit = 0;

	invaders_top #(
		.NUM_SHOTS(3)
	) i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.x(x),
		.y(y),
		.btn_left(btn_left),
		.btn_right(btn_right),
		.btn_fire(btn_fire),
		.rgb(rgb)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#50 clk = ~clk;
	end

	// guard against a run that outlasts the data file
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit)
		begin
			$display("timeout: stimulus still running after %0d cycles", cycles);
			$display("TEST FAIL");
			$finish;
		end
	end

	// one pixel per cycle, changed on the falling edge
	task automatic drive_pixel(input int px, input int py);
		@(negedge clk);
		x = 11'(px);
		y = 11'(py);
	endtask

	// frame start at (0,0), then two idle off-screen pixels
	task automatic run_frames(input logic left, input logic right, input logic fire,
		input int count);
		int i;
		for (i = 0; i < count; i++)
		begin
			@(negedge clk);
			btn_left = left;
			btn_right = right;
			btn_fire = fire;
			x = '0;
			y = '0;
			drive_pixel(IDLE_X, 0);
			drive_pixel(IDLE_X, 0);
		end
		btn_left = 1'b0;
		btn_right = 1'b0;
		btn_fire = 1'b0;
	endtask

	task automatic probe_pixel(input int px, input int py, input logic [7:0] expected);
		drive_pixel(px, py);
		// colour is registered, so read it one cycle on
		@(negedge clk);
		checks++;
		if (rgb !== expected)
		begin
			errors++;
			$display("ERR %0t rgb at (%0d,%0d): expected %h, got %h",
				$time, px, py, expected, rgb);
		end
		x = 11'(IDLE_X);
		y = '0;
	endtask

	task automatic reject_line(input string line);
		errors++;
		$display("data file line not understood: %s", line);
	endtask

	// cycles asked for by the data file, sizes the timeout
	task automatic measure_file(output int total, output logic found);
		int fd;
		int a;
		int b;
		int c;
		int d;
		string line;
		total = RESET_CYCLES;
		fd = $fopen(INPUT_FILE, "r");
		found = (fd != 0);
		if (fd != 0)
		begin
			while ($fgets(line, fd) != 0)
			begin
				if (line.len() > 0 && line[0] == "F"
					&& $sscanf(line, "F %d %d %d %d", a, b, c, d) == 4)
					total += FRAME_CYCLES * d;
				else if (line.len() > 0 && line[0] == "P")
					total += PROBE_CYCLES;
			end
			$fclose(fd);
		end
	endtask

	task automatic play_file();
		int fd;
		int a;
		int b;
		int c;
		int d;
		logic [7:0] expected;
		logic done;
		string line;
		done = 1'b0;
		fd = $fopen(INPUT_FILE, "r");
		while (!done && $fgets(line, fd) != 0)
		begin
			// comments and blank lines
			if (line.len() == 0 || line[0] == "#" || line[0] == "\n")
				continue;
			case (line[0])
				"F":
				begin
					if ($sscanf(line, "F %d %d %d %d", a, b, c, d) == 4)
						run_frames(a != 0, b != 0, c != 0, d);
					else
						reject_line(line);
				end
				"P":
				begin
					if ($sscanf(line, "P %d %d %h", a, b, expected) == 3)
						probe_pixel(a, b, expected);
					else
						reject_line(line);
				end
				"E":
					done = 1'b1;
				default:
					reject_line(line);
			endcase
		end
		$fclose(fd);
		if (!done)
		begin
			errors++;
			$display("data file ended without its end line");
		end
	endtask

	initial
	begin
		int total;
		logic found;
		rst_n = 1'b0;
		x = 11'(IDLE_X);
		y = '0;
		btn_left = 1'b0;
		btn_right = 1'b0;
		btn_fire = 1'b0;
		measure_file(total, found);
		cycle_limit = 3 * total;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		if (found)
			play_file();
		else
		begin
			errors++;
			$display("cannot open the data file %s", INPUT_FILE);
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire
